//--- hdl/dot_product_lane.sv
`timescale 1ns/1ps
// dot product lane
// multiplies one row of A by the issued column of B and sums,
// result registered with its column tag after one cycle

module dot_product_lane (
    input  logic                  clk,
    input  logic                  resetn,
    input  mm_cfg_pkg::vec_t      a_row,
    input  mm_cfg_pkg::vec_t      b_col,
    input  logic                  col_issue,
    input  mm_cfg_pkg::idx_t      col_sel,
    output mm_bus_pkg::lane_out_t lane_out
);

    mm_cfg_pkg::sum_t dot;

    always_comb begin
        dot = '0;
        for (int k = 0; k < mm_cfg_pkg::mat_dim; k++) begin
            // 4x4 product fits in 8 bits, the sum wraps
            dot = dot + mm_cfg_pkg::sum_t'(a_row[k]) * mm_cfg_pkg::sum_t'(b_col[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lane_out.we <= 1'b0;
        end else begin
            lane_out.we <= col_issue;
        end
    end

    always_ff @(posedge clk) begin
        lane_out.col <= col_sel;   // tag follows the sum
        lane_out.sum <= dot;
    end

    // a compute issues at most three columns back to back
    a_we_burst: assert property (
        @(posedge clk) disable iff (!resetn)
        lane_out.we [*3] |=> !lane_out.we
    ) else $error("lane write burst longer than a matrix");

endmodule

//--- hdl/matrix_multiply.sv
`timescale 1ns/1ps
// 3x3 matrix multiply engine
// operand store, one dot product lane per row of C,
// sequencer and result store

module matrix_multiply (
    input  logic                     clk,
    input  logic                     resetn,
    input  mm_bus_pkg::load_req_t    load,
    input  logic                     start,
    output logic                     done,
    input  logic                     read,
    output mm_bus_pkg::result_beat_t result,
    output logic                     read_done
);

    logic                  busy;
    logic                  col_issue;
    mm_cfg_pkg::idx_t      col_sel;
    logic                  rd_issue;
    mm_cfg_pkg::idx_t      rd_row;
    logic                  read_last;   // held back one cycle to meet the beat
    mm_cfg_pkg::vec_t      a_rows   [mm_cfg_pkg::mat_dim];
    mm_cfg_pkg::vec_t      b_col;
    mm_bus_pkg::lane_out_t lane_out [mm_cfg_pkg::mat_dim];

    operand_store i_operand_store (
        .clk     (clk),
        .resetn  (resetn),
        .load    (load),
        .busy    (busy),
        .col_sel (col_sel),
        .a_rows  (a_rows),
        .b_col   (b_col)
    );

    mm_sequencer i_mm_sequencer (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .read      (read),
        .busy      (busy),
        .col_issue (col_issue),
        .col_sel   (col_sel),
        .rd_issue  (rd_issue),
        .rd_row    (rd_row),
        .done      (done),
        .read_done (read_last)
    );

    for (genvar i = 0; i < mm_cfg_pkg::mat_dim; i++) begin : gen_lane
        dot_product_lane i_dot_product_lane (
            .clk       (clk),
            .resetn    (resetn),
            .a_row     (a_rows[i]),
            .b_col     (b_col),
            .col_issue (col_issue),
            .col_sel   (col_sel),
            .lane_out  (lane_out[i])
        );
    end

    result_store i_result_store (
        .clk       (clk),
        .resetn    (resetn),
        .lane_out  (lane_out),
        .rd_issue  (rd_issue),
        .rd_row    (rd_row),
        .read_last (read_last),
        .result    (result),
        .read_done (read_done)
    );

endmodule

//--- hdl/mm_bus_pkg.sv
// matrix multiply bus types
// load port toward the operand store, lane result word
// and the result beat streamed out on a read

package mm_bus_pkg;

    // one row of A or one column of B per cycle
    typedef struct packed {
        logic             row_we;
        logic             col_we;
        mm_cfg_pkg::idx_t addr;
        mm_cfg_pkg::vec_t data;
    } load_req_t;

    // one row of C, no back-pressure
    typedef struct packed {
        logic                 valid;
        mm_cfg_pkg::idx_t     row;
        mm_cfg_pkg::res_vec_t data;
    } result_beat_t;

    // lane sum tagged with its column of C
    typedef struct packed {
        logic             we;
        mm_cfg_pkg::idx_t col;
        mm_cfg_pkg::sum_t sum;
    } lane_out_t;

endpackage

//--- hdl/mm_cfg_pkg.sv
// matrix multiply configuration
// matrix side, element widths and the row/column vector types
// shared by the datapath, the control and the testbench

package mm_cfg_pkg;

    localparam int mat_dim = 3;
    localparam int elem_w  = 4;
    localparam int sum_w   = 8;
    localparam int idx_w   = 2;

    // column issue to its write into C
    localparam int col_done_cycles = 2;

    typedef logic [idx_w-1:0]  idx_t;
    typedef logic [elem_w-1:0] elem_t;
    typedef logic [sum_w-1:0]  sum_t;   // wraps modulo 256

    // element 0 in the low bits
    typedef elem_t [mat_dim-1:0] vec_t;
    typedef sum_t  [mat_dim-1:0] res_vec_t;

    localparam idx_t last_idx = idx_t'(mat_dim - 1);

endpackage

//--- hdl/mm_sequencer.sv
`timescale 1ns/1ps
// matrix multiply sequencer
// steps the columns of a compute one per cycle, waits out the
// lane pipeline for done, and steps the rows of a read

module mm_sequencer (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  logic             read,
    output logic             busy,
    output logic             col_issue,
    output mm_cfg_pkg::idx_t col_sel,
    output logic             rd_issue,
    output mm_cfg_pkg::idx_t rd_row,
    output logic             done,
    output logic             read_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_drain,
        st_read
    } state_t;

    state_t           state;
    mm_cfg_pkg::idx_t drain_cnt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= st_idle;
            busy      <= 1'b0;
            col_issue <= 1'b0;
            col_sel   <= '0;
            rd_issue  <= 1'b0;
            rd_row    <= '0;
            drain_cnt <= '0;
            done      <= 1'b0;
            read_done <= 1'b0;
        end else begin
            done      <= 1'b0;
            read_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin   // start wins over read
                        state     <= st_compute;
                        busy      <= 1'b1;
                        col_issue <= 1'b1;
                        col_sel   <= '0;
                    end else if (read) begin
                        state    <= st_read;
                        rd_issue <= 1'b1;
                        rd_row   <= '0;
                    end
                end
                st_compute: begin
                    if (col_sel == mm_cfg_pkg::last_idx) begin
                        col_issue <= 1'b0;
                        drain_cnt <= '0;
                        state     <= st_drain;
                    end else begin
                        col_sel <= col_sel + 2'd1;
                    end
                end
                st_drain: begin
                    // last column still in the lane and result store
                    if (drain_cnt == mm_cfg_pkg::idx_t'(mm_cfg_pkg::col_done_cycles - 1)) begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= st_idle;
                    end else begin
                        drain_cnt <= drain_cnt + 2'd1;
                    end
                end
                st_read: begin
                    if (rd_row == mm_cfg_pkg::last_idx) begin
                        rd_issue <= 1'b0;
                        state    <= st_idle;
                    end else begin
                        rd_row    <= rd_row + 2'd1;
                        read_done <= (rd_row + 2'd1 == mm_cfg_pkg::last_idx);  // marks row 2
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_issue_excl: assert property (
        @(posedge clk) disable iff (!resetn)
        !(col_issue && rd_issue)
    ) else $error("compute and read issued together");

    // done only right after the drain of the last column, so never two cycles long
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!resetn)
        done |-> $past(col_issue, mm_cfg_pkg::col_done_cycles + 1) &&
                 !$past(col_issue, mm_cfg_pkg::col_done_cycles)
    ) else $error("done not a single pulse after the column drain");

endmodule

//--- hdl/operand_store.sv
`timescale 1ns/1ps
// operand store
// register files for the rows of A and the columns of B
// all A rows and the selected B column go to the lanes

module operand_store (
    input  logic                  clk,
    input  logic                  resetn,
    input  mm_bus_pkg::load_req_t load,
    input  logic                  busy,
    input  mm_cfg_pkg::idx_t      col_sel,
    output mm_cfg_pkg::vec_t      a_rows [mm_cfg_pkg::mat_dim],
    output mm_cfg_pkg::vec_t      b_col
);

    mm_cfg_pkg::vec_t a_mem [mm_cfg_pkg::mat_dim];   // row i of A
    mm_cfg_pkg::vec_t b_mem [mm_cfg_pkg::mat_dim];   // element j is B[j][col]
    logic             load_ok;

    // operands frozen during a compute, address 3 dropped
    assign load_ok = resetn && !busy && (load.addr <= mm_cfg_pkg::last_idx);

    always_ff @(posedge clk) begin
        if (load_ok && load.row_we) begin
            a_mem[load.addr] <= load.data;
        end
        if (load_ok && load.col_we) begin
            b_mem[load.addr] <= load.data;
        end
    end

    // every lane sees its own row and the shared column
    assign a_rows = a_mem;
    assign b_col  = b_mem[col_sel];

    a_one_target: assert property (
        @(posedge clk) disable iff (!resetn)
        !(load.row_we && load.col_we)
    ) else $error("row and column write in the same cycle");

endmodule

//--- hdl/result_store.sv
`timescale 1ns/1ps
// result store
// collects the lane sums into C by column tag and streams
// one row of C per read issue, read_done aligned to the last beat

module result_store (
    input  logic                     clk,
    input  logic                     resetn,
    input  mm_bus_pkg::lane_out_t    lane_out [mm_cfg_pkg::mat_dim],
    input  logic                     rd_issue,
    input  mm_cfg_pkg::idx_t         rd_row,
    input  logic                     read_last,
    output mm_bus_pkg::result_beat_t result,
    output logic                     read_done
);

    mm_cfg_pkg::res_vec_t c_mem [mm_cfg_pkg::mat_dim];   // row i of C

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < mm_cfg_pkg::mat_dim; i++) begin
                c_mem[i] <= '0;
            end
            result    <= '0;
            read_done <= 1'b0;
        end else begin
            // lane i owns row i of C
            for (int i = 0; i < mm_cfg_pkg::mat_dim; i++) begin
                if (lane_out[i].we) begin
                    c_mem[i][lane_out[i].col] <= lane_out[i].sum;
                end
            end
            result.valid <= rd_issue;
            if (rd_issue) begin
                result.row  <= rd_row;
                result.data <= c_mem[rd_row];
            end
            read_done <= read_last;
        end
    end

    // lanes run in lockstep on one column
    a_lane_lockstep: assert property (
        @(posedge clk) disable iff (!resetn)
        lane_out[0].we |-> (lane_out[1].we && lane_out[2].we &&
                            lane_out[1].col == lane_out[0].col &&
                            lane_out[2].col == lane_out[0].col)
    ) else $error("lanes out of step");

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_matrix_multiply \
    -f sim.f \
    -Mdir obj_dir

./obj_dir/Vtb_matrix_multiply

//--- sim.f
+incdir+test
hdl/mm_cfg_pkg.sv
hdl/mm_bus_pkg.sv
hdl/operand_store.sv
hdl/dot_product_lane.sv
hdl/mm_sequencer.sv
hdl/result_store.sv
hdl/matrix_multiply.sv
test/tb_matrix_multiply.sv

//--- test/tb_checks.svh
// matrix multiply testbench helpers
// LFSR stimulus, reference product model and compare tasks

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// whole matrices, row i in slot i
typedef mm_cfg_pkg::vec_t     [mm_cfg_pkg::mat_dim-1:0] mat_t;
typedef mm_cfg_pkg::res_vec_t [mm_cfg_pkg::mat_dim-1:0] res_mat_t;

logic [31:0] lfsr_state = 32'h0335_a584;

// fibonacci, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic mat_t random_matrix();
    mat_t m;
    for (int i = 0; i < mm_cfg_pkg::mat_dim; i++) begin
        for (int k = 0; k < mm_cfg_pkg::mat_dim; k++) begin
            for (int n = 0; n < mm_cfg_pkg::elem_w; n++) begin
                m[i][k][n] = lfsr_bit();   // one step per bit
            end
        end
    end
    return m;
endfunction

// element k of column j is B[k][j]
function automatic mm_cfg_pkg::vec_t column_of(input mat_t m, input int j);
    mm_cfg_pkg::vec_t v;
    for (int k = 0; k < mm_cfg_pkg::mat_dim; k++) begin
        v[k] = m[k][j];
    end
    return v;
endfunction

// C[i][j] is the sum of A[i][k] * B[k][j], modulo 256
function automatic res_mat_t model_product(input mat_t a, input mat_t b);
    res_mat_t c;
    int       acc;
    for (int i = 0; i < mm_cfg_pkg::mat_dim; i++) begin
        for (int j = 0; j < mm_cfg_pkg::mat_dim; j++) begin
            acc = 0;
            for (int k = 0; k < mm_cfg_pkg::mat_dim; k++) begin
                acc += int'(a[i][k]) * int'(b[k][j]);
            end
            c[i][j] = mm_cfg_pkg::sum_t'(acc % 256);
        end
    end
    return c;
endfunction

function automatic mm_bus_pkg::result_beat_t expected_beat(input res_mat_t c, input int row);
    mm_bus_pkg::result_beat_t beat;
    beat.valid = 1'b1;
    beat.row   = mm_cfg_pkg::idx_t'(row);
    beat.data  = c[row];
    return beat;
endfunction

task automatic check_bit(input logic got, input logic want, input string what);
    if (got !== want) begin
        report_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
                                 $time, what, got, want));
    end
endtask

task automatic check_sum(input mm_cfg_pkg::sum_t got, input mm_cfg_pkg::sum_t want,
                         input string what);
    if (got !== want) begin
        report_failure($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                                 $time, what, got, want));
    end
endtask

task automatic check_beat(input mm_bus_pkg::result_beat_t got,
                          input mm_bus_pkg::result_beat_t want, input string what);
    check_bit(got.valid, want.valid, {what, " valid"});
    if (got.row !== want.row) begin
        report_failure($sformatf("mismatch at %0t: %s row is %0d, expected %0d",
                                 $time, what, got.row, want.row));
    end
    for (int j = 0; j < mm_cfg_pkg::mat_dim; j++) begin
        check_sum(got.data[j], want.data[j],
                  $sformatf("%s C[%0d][%0d]", what, want.row, j));
    end
endtask

`endif

//--- test/tb_matrix_multiply.sv
`timescale 1ns/1ps
// testbench for the 3x3 matrix multiply engine
// directed load, compute and read tests against a reference model

module tb_matrix_multiply;

    localparam int wait_limit      = 20;   // cycles before a wait gives up
    localparam int compute_latency = 5;    // start edge to done

    logic                     clk;
    logic                     resetn;
    mm_bus_pkg::load_req_t    load;
    logic                     start;
    logic                     done;
    logic                     read;
    mm_bus_pkg::result_beat_t result;
    logic                     read_done;

    matrix_multiply i_matrix_multiply (
        .clk       (clk),
        .resetn    (resetn),
        .load      (load),
        .start     (start),
        .done      (done),
        .read      (read),
        .result    (result),
        .read_done (read_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    `include "tb_checks.svh"

    // inputs move 1 ns past the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic write_operand(input logic is_row, input mm_cfg_pkg::idx_t addr,
                                 input mm_cfg_pkg::vec_t data);
        load.row_we = is_row;
        load.col_we = !is_row;
        load.addr   = addr;
        load.data   = data;
        tick();
        load = '0;
    endtask

    task automatic load_matrices(input mat_t a, input mat_t b);
        for (int i = 0; i < mm_cfg_pkg::mat_dim; i++) begin
            write_operand(1'b1, mm_cfg_pkg::idx_t'(i), a[i]);
        end
        for (int j = 0; j < mm_cfg_pkg::mat_dim; j++) begin
            write_operand(1'b0, mm_cfg_pkg::idx_t'(j), column_of(b, j));
        end
    endtask

    // busy_load goes out in the first busy cycle
    task automatic run_compute(input mm_bus_pkg::load_req_t busy_load);
        int cycles;
        cycles = 0;
        start  = 1'b1;
        tick();
        start = 1'b0;
        load  = busy_load;
        while (!done) begin
            tick();
            load = '0;
            cycles++;
            check_bit(done, cycles == compute_latency, $sformatf("done at cycle %0d", cycles));
            check_bit(result.valid, 1'b0, "result.valid during compute");
            if (cycles > wait_limit) begin
                report_failure("timeout: done never came after start");
            end
        end
        tick();
        check_bit(done, 1'b0, "done one cycle after its pulse");
    endtask

    task automatic read_result(input res_mat_t want);
        int cycles;
        cycles = 0;
        read   = 1'b1;
        tick();
        read = 1'b0;
        while (!result.valid) begin
            tick();
            cycles++;
            if (cycles > wait_limit) begin
                report_failure("timeout: no result beat after read");
            end
        end
        for (int i = 0; i < mm_cfg_pkg::mat_dim; i++) begin
            check_beat(result, expected_beat(want, i), "result beat");
            check_bit(read_done, i == mm_cfg_pkg::mat_dim - 1, "read_done");
            tick();
        end
        check_bit(result.valid, 1'b0, "result.valid after the last row");
        check_bit(read_done, 1'b0, "read_done after the last row");
    endtask

    initial begin
        mat_t                  a;
        mat_t                  b;
        res_mat_t              want;
        res_mat_t              old;
        mm_bus_pkg::load_req_t stray;

        resetn = 1'b0;
        load   = '0;
        start  = 1'b0;
        read   = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;

        // quiet after reset, C cleared
        repeat (4) begin
            tick();
            check_bit(done, 1'b0, "done after reset");
            check_bit(read_done, 1'b0, "read_done after reset");
            check_bit(result.valid, 1'b0, "result.valid after reset");
        end
        read_result('0);

        // identity A gives back B row by row
        a = '0;
        for (int i = 0; i < mm_cfg_pkg::mat_dim; i++) begin
            a[i][i] = 4'd1;
        end
        b = random_matrix();
        load_matrices(a, b);
        run_compute('0);
        for (int i = 0; i < mm_cfg_pkg::mat_dim; i++) begin
            for (int j = 0; j < mm_cfg_pkg::mat_dim; j++) begin
                want[i][j] = mm_cfg_pkg::sum_t'(b[i][j]);
            end
        end
        read_result(want);

        repeat (4) begin
            a = random_matrix();
            b = random_matrix();
            load_matrices(a, b);
            run_compute('0);
            read_result(model_product(a, b));
        end

        // all elements 15, 3 * 225 = 675 wraps to 163
        a = '1;
        b = '1;
        load_matrices(a, b);
        run_compute('0);
        for (int i = 0; i < mm_cfg_pkg::mat_dim; i++) begin
            for (int j = 0; j < mm_cfg_pkg::mat_dim; j++) begin
                want[i][j] = 8'd163;
            end
        end
        read_result(want);

        // write to row 0 of A while busy must be dropped
        a = random_matrix();
        b = random_matrix();
        load_matrices(a, b);
        stray        = '0;
        stray.row_we = 1'b1;
        stray.addr   = 2'd0;
        stray.data   = ~a[0];
        run_compute(stray);
        read_result(model_product(a, b));
        run_compute('0);
        read_result(model_product(a, b));

        // new row 1 of A moves only row 1 of C
        old  = model_product(a, b);
        a[1] = ~a[1];
        write_operand(1'b1, 2'd1, a[1]);
        run_compute('0);
        want    = model_product(a, b);
        want[0] = old[0];
        want[2] = old[2];
        read_result(want);

        $display("All checks passed");
        $finish;
    end

endmodule
